// ==== image_rom.hex ====
// three 16-word slots: width hi, width lo, height hi, height lo, then pixels row by row
// pixel 24 is transparent
// slot 0, 3 wide by 4 high
00 03 00 04
01 02 24 03 24 04 05 06 07 24 08 09
// slot 1, 4 wide by 3 high
00 04 00 03
11 12 13 14 24 15 16 24 17 18 19 1a
// slot 2, 2 wide by 5 high, two spare words
00 02 00 05
21 22 23 25 24 26 27 28 29 2a 00 00

// ==== font_rom.hex ====
// font strip, 8 pixels per row and 4 rows
// glyph 0 in columns 0 to 3, glyph 1 in columns 4 to 7
31 32 33 34 24 3a 3b 24
35 24 24 36 3c 3d 3e 3f
37 24 24 38 24 2b 2c 24
39 30 2f 2e 2d 24 24 1f

// ==== list.f ====
+incdir+.
place_pkg.sv
place_ctrl.sv
place_addr_gen.sv
bmp_store.sv
video_mem.sv
place_top.sv
place_sva.sv
place_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the placer testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module place_tb -o place_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/place_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi
exit 0

// ==== place_tb.sv ====
`include "place_consts.svh"

module place_tb import place_pkg::*; ();

  localparam logic [1:0] K_ADD = 2'd0;  // command kinds in the table
  localparam logic [1:0] K_REM = 2'd1;
  localparam logic [1:0] K_FNT = 2'd2;
  localparam int ROWS   = 8;
  localparam int EXTRAS = 6;  // seeded placements after the table
  localparam int CYCLE_LIMIT = (ROWS + EXTRAS) * (`SLOT_WORDS + 16) + 2 * `FRAME_WORDS + 200;

  typedef struct packed {
    logic [1:0] kind;
    logic [1:0] idx;    // image slot or glyph number
    xcoord_t    x;
    ycoord_t    y;
    logic       stray;  // extra rem_img pulse while busy
  } cmd_row_t;

  logic       clk = 1'b0;
  logic       rst_n, add_img, rem_img, add_fnt;
  img_idx_t   image_indx;
  glyph_idx_t fnt_indx;
  xcoord_t    xloc;
  ycoord_t    yloc;
  vaddr_t     rd_addr;
  logic       busy;
  pix_t       rd_data;

  pix_t     img_mdl [`IMG_CNT * `SLOT_WORDS];     // copy of the image rom
  pix_t     fnt_mdl [`FONT_STRIDE * `GLYPH_H];    // copy of the font strip
  pix_t     frame_mdl [`FRAME_WORDS];             // expected frame
  cmd_row_t cmd_tab [ROWS];
  int       cycles = 0;

  always #10 clk = ~clk;

  place_top i_dut (
    .clk, .rst_n, .add_img, .rem_img, .add_fnt, .image_indx, .fnt_indx,
    .xloc, .yloc, .rd_addr, .busy, .rd_data
  );

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // frame model
  ////////////////////
  task automatic image_dims(input int idx, output int w, output int h);
    int base;
    base = idx * `SLOT_WORDS;
    w = int'(img_mdl[base]) * 64 + int'(img_mdl[base + 1]);      // two 6-bit digits
    h = int'(img_mdl[base + 2]) * 64 + int'(img_mdl[base + 3]);
  endtask

  task automatic model_apply(input cmd_row_t c);
    int   w, h, base;
    pix_t p;
    if (c.kind == K_FNT) begin
      w = `GLYPH_W;
      h = `GLYPH_H;
    end else begin
      image_dims(int'(c.idx), w, h);
    end
    base = c.idx * `SLOT_WORDS + `HDR_WORDS;  // first pixel of the slot
    for (int r = 0; r < h; r++) begin
      for (int col = 0; col < w; col++) begin
        if (c.kind == K_FNT) p = fnt_mdl[r * `FONT_STRIDE + c.idx * `GLYPH_W + col];
        else p = img_mdl[base + r * w + col];
        if (p != `TRANSP)  // key code leaves the frame alone
          frame_mdl[(c.y + r) * `FRAME_W + c.x + col] = (c.kind == K_REM) ? '0 : p;
      end
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  task automatic run_cmd(input cmd_row_t c);
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    add_img    <= (c.kind == K_ADD);
    rem_img    <= (c.kind == K_REM);
    add_fnt    <= (c.kind == K_FNT);
    image_indx <= c.idx;
    fnt_indx   <= c.idx[0];
    xloc       <= c.x;
    yloc       <= c.y;
    @(posedge clk);  // pulse taken at this edge
    add_img <= 1'b0;
    rem_img <= 1'b0;
    add_fnt <= 1'b0;
    @(negedge clk);
    assert (busy) else begin
      $display("[FAIL] busy: expected %h, got %h", 1'b1, busy);
      $display("TEST FAIL");
      $fatal(1, "busy low after accept");
    end
    if (c.stray) begin
      @(posedge clk);
      rem_img <= 1'b1;  // dropped since the DUT is busy
      @(posedge clk);
      rem_img <= 1'b0;
      @(negedge clk);
    end
    while (busy) @(negedge clk);  // fall of busy ends the command
    model_apply(c);
  endtask

  // read port answers one cycle late, so check address a-1 each cycle
  task automatic sweep_frame();
    pix_t want;
    for (int a = 0; a <= `FRAME_WORDS; a++) begin
      @(posedge clk);
      if (a < `FRAME_WORDS) rd_addr <= vaddr_t'(a);
      @(negedge clk);
      if (a > 0) begin
        want = frame_mdl[a - 1];
        assert (rd_data == want) else begin
          $display("[FAIL] rd_data at %h: expected %h, got %h", a - 1, want, rd_data);
          $display("TEST FAIL");
          $fatal(1, "frame mismatch");
        end
      end
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    cmd_row_t c;
    int       w, h;
    rst_n      = 1'b0;
    add_img    = 1'b0;
    rem_img    = 1'b0;
    add_fnt    = 1'b0;
    image_indx = '0;
    fnt_indx   = '0;
    xloc       = '0;
    yloc       = '0;
    rd_addr    = '0;
    void'($urandom(32'h1cbdba14));
    $readmemh("image_rom.hex", img_mdl);
    $readmemh("font_rom.hex", fnt_mdl);
    foreach (frame_mdl[i]) frame_mdl[i] = '0;

    cmd_tab[0] = '{2'(K_ADD), 2'd0, 6'd2, 5'd1, 1'b0};
    cmd_tab[1] = '{2'(K_ADD), 2'd1, 6'd4, 5'd2, 1'b0};    // over image 0
    cmd_tab[2] = '{2'(K_ADD), 2'd2, 6'd62, 5'd27, 1'b0};  // bottom right corner
    cmd_tab[3] = '{2'(K_FNT), 2'd0, 6'd4, 5'd3, 1'b0};    // glyph across both images
    cmd_tab[4] = '{2'(K_FNT), 2'd1, 6'd60, 5'd0, 1'b0};
    cmd_tab[5] = '{2'(K_REM), 2'd0, 6'd2, 5'd1, 1'b0};
    cmd_tab[6] = '{2'(K_ADD), 2'd1, 6'd20, 5'd10, 1'b1};
    cmd_tab[7] = '{2'(K_FNT), 2'd1, 6'd30, 5'd20, 1'b1};

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!busy) else begin
      $display("[FAIL] busy: expected %h, got %h", 1'b0, busy);
      $display("TEST FAIL");
      $fatal(1, "busy after reset");
    end
    sweep_frame();  // blank frame out of reset

    for (int i = 0; i < ROWS; i++) run_cmd(cmd_tab[i]);

    // seeded placements kept inside the frame
    for (int i = 0; i < EXTRAS; i++) begin
      c.kind = 2'($urandom % 3);
      if (c.kind == K_FNT) begin
        c.idx = 2'($urandom % `GLYPH_CNT);
        w = `GLYPH_W;
        h = `GLYPH_H;
      end else begin
        c.idx = 2'($urandom % `IMG_CNT);
        image_dims(int'(c.idx), w, h);
      end
      c.x     = xcoord_t'($urandom % (`FRAME_W - w + 1));
      c.y     = ycoord_t'($urandom % (`FRAME_H - h + 1));
      c.stray = 1'b0;
      run_cmd(c);
    end

    sweep_frame();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== place_sva.sv ====
`include "place_consts.svh"

module place_sva import place_pkg::*; (
  input logic         clk,
  input logic         rst_n,
  input place_state_t state,
  input logic         busy,
  input logic         we,
  input pix_t         wdata
);

  ////////////////////
  // controller protocol
  ////////////////////
  idle_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    (state == IDLE) |-> !we)  // frame untouched between commands
    else $error("write strobe high while the controller is idle");

  reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
    else $error("busy high right after reset release");

  ////////////////////
  // write data
  ////////////////////
  no_transp_write: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> (wdata == '0 || wdata != `TRANSP))  // zero on remove and never the key code
    else $error("transparent pixel reached the frame buffer");

endmodule

bind place_ctrl place_sva i_sva (.clk, .rst_n, .state, .busy, .we, .wdata);

// ==== place_top.sv ====
module place_top import place_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       add_img,
  input  logic       rem_img,
  input  logic       add_fnt,
  input  img_idx_t   image_indx,
  input  glyph_idx_t fnt_indx,
  input  xcoord_t    xloc,
  input  ycoord_t    yloc,
  input  vaddr_t     rd_addr,     // frame scan out address
  output logic       busy,
  output pix_t       rd_data
);

  ////////////////////
  // controller to counters
  ////////////////////
  logic cmd_start, img_mode, img_inc, gly_inc, vid_inc;
  logic hdr_xhi, hdr_xlo, hdr_yhi, hdr_ylo;
  logic row_end, gly_row_end, gly_last, img_done;

  // rom and frame buffer paths
  rom_addr_t  img_addr;
  font_addr_t font_addr;
  pix_t       rd_pix;
  logic       we;
  pix_t       wdata;
  vaddr_t     waddr;

  place_ctrl i_ctrl (
    .clk, .rst_n, .add_img, .rem_img, .add_fnt, .rd_pix,
    .img_done, .row_end, .gly_row_end, .gly_last,
    .busy, .we, .cmd_start, .img_mode, .img_inc, .gly_inc, .vid_inc,
    .hdr_xhi, .hdr_xlo, .hdr_yhi, .hdr_ylo, .wdata
  );

  place_addr_gen i_addr_gen (
    .clk, .rst_n, .cmd_start, .img_mode, .img_inc, .gly_inc, .vid_inc,
    .hdr_xhi, .hdr_xlo, .hdr_yhi, .hdr_ylo, .rd_pix,
    .image_indx, .fnt_indx, .xloc, .yloc,
    .img_addr, .font_addr, .waddr, .row_end, .gly_row_end, .gly_last, .img_done
  );

  bmp_store i_bmp_store (.clk, .img_mode, .img_addr, .font_addr, .rd_pix);

  video_mem i_video_mem (.clk, .we, .waddr, .wdata, .rd_addr, .rd_data);

endmodule

// ==== video_mem.sv ====
`include "place_consts.svh"

module video_mem import place_pkg::*; (
  input  logic   clk,
  input  logic   we,        // write strobe from the placer
  input  vaddr_t waddr,
  input  pix_t   wdata,
  input  vaddr_t rd_addr,   // scan out side
  output pix_t   rd_data
);

  pix_t mem [`FRAME_WORDS];  // one word per pixel, row major

  // frame starts out blank
  initial begin
    for (int i = 0; i < `FRAME_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  ////////////////////
  // write port
  ////////////////////
  always_ff @(posedge clk) begin
    if (we) mem[waddr] <= wdata;
  end

  // read port, old data on a same address collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== bmp_store.sv ====
`include "place_consts.svh"

module bmp_store import place_pkg::*; (
  input  logic       clk,
  input  logic       img_mode,   // which rom feeds rd_pix
  input  rom_addr_t  img_addr,
  input  font_addr_t font_addr,
  output pix_t       rd_pix
);

  localparam int IMG_WORDS  = `IMG_CNT * `SLOT_WORDS;     // all slots back to back
  localparam int FONT_WORDS = `FONT_STRIDE * `GLYPH_H;    // strip rows back to back

  pix_t img_rom  [IMG_WORDS];
  pix_t font_rom [FONT_WORDS];
  pix_t img_q;        // registered image rom read
  pix_t font_q;       // registered font rom read
  logic img_sel_q;    // select lined up with the read data

  ////////////////////
  // rom contents
  ////////////////////
  initial begin
    $readmemh("image_rom.hex", img_rom);   // header then raster pixels per slot
    $readmemh("font_rom.hex", font_rom);   // glyphs side by side, row major
  end

  // both roms read every cycle
  always_ff @(posedge clk) begin
    img_q  <= img_rom[img_addr];
    font_q <= font_rom[font_addr];
  end

  // mode seen with the address, used with the data
  always_ff @(posedge clk) begin
    img_sel_q <= img_mode;
  end

  assign rd_pix = img_sel_q ? img_q : font_q;

endmodule

// ==== place_addr_gen.sv ====
`include "place_consts.svh"

module place_addr_gen import place_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_start,
  input  logic       img_mode,
  input  logic       img_inc,
  input  logic       gly_inc,
  input  logic       vid_inc,
  input  logic       hdr_xhi,
  input  logic       hdr_xlo,
  input  logic       hdr_yhi,
  input  logic       hdr_ylo,
  input  pix_t       rd_pix,       // header digits arrive here
  input  img_idx_t   image_indx,
  input  glyph_idx_t fnt_indx,
  input  xcoord_t    xloc,
  input  ycoord_t    yloc,
  output rom_addr_t  img_addr,
  output font_addr_t font_addr,
  output vaddr_t     waddr,
  output logic       row_end,
  output logic       gly_row_end,
  output logic       gly_last,
  output logic       img_done
);

  localparam int GCW = $clog2(`GLYPH_W);
  localparam int GRW = $clog2(`GLYPH_H);

  img_idx_t    idx_q;       // slot of the running command
  rom_addr_t   new_base;    // slot base for a new command
  rom_addr_t   cur_base;
  rom_addr_t   img_end;     // address of the last image pixel
  dim_t        img_w;
  dim_t        img_h;
  dim_t        h_full;      // height once the low digit is on rd_pix
  dim_t        img_col;     // image column being written
  dim_t        row_w;       // width of whatever is being placed
  logic [23:0] area;
  logic [23:0] end_sum;
  logic [GCW-1:0] gly_col;
  logic [GRW-1:0] gly_row;
  logic        row_wrap;

  assign new_base = rom_addr_t'(image_indx) * rom_addr_t'(`SLOT_WORDS);
  assign cur_base = rom_addr_t'(idx_q) * rom_addr_t'(`SLOT_WORDS);
  assign h_full   = img_h + dim_t'(rd_pix);
  assign area     = {12'b0, img_w} * {12'b0, h_full};
  assign end_sum  = 24'(cur_base) + 24'(`HDR_WORDS - 1) + area;

  assign row_end     = img_mode && (img_col == img_w - dim_t'(1));
  assign gly_row_end = !img_mode && (gly_col == GCW'(`GLYPH_W - 1));
  assign gly_last    = (gly_row == GRW'(`GLYPH_H - 1));
  assign img_done    = (img_addr > img_end);  // rom runs one ahead of the write
  assign row_w       = img_mode ? img_w : dim_t'(`GLYPH_W);
  assign row_wrap    = img_mode ? row_end : gly_row_end;

  ////////////////////
  // header capture
  ////////////////////
  always_ff @(posedge clk) begin
    if (cmd_start) idx_q <= image_indx;
    if (hdr_xhi) img_w <= {rd_pix, 6'b0};
    if (hdr_xlo) img_w <= img_w + dim_t'(rd_pix);
    if (hdr_yhi) img_h <= {rd_pix, 6'b0};
    if (hdr_ylo) begin
      img_h   <= h_full;
      img_end <= rom_addr_t'(end_sum);  // base + header + w*h - 1
    end
  end

  ////////////////////
  // rom addresses
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      img_addr  <= '0;
      font_addr <= '0;
    end else if (cmd_start) begin
      img_addr  <= new_base;
      font_addr <= font_addr_t'(fnt_indx) * font_addr_t'(`GLYPH_W);  // glyph column base
    end else begin
      if (img_inc) img_addr <= img_addr + 1'b1;
      if (gly_inc) begin
        if (gly_row_end) font_addr <= font_addr + font_addr_t'(`FONT_STRIDE - `GLYPH_W);
        else font_addr <= font_addr + 1'b1;
      end
    end
  end

  ////////////////////
  // video address and counters
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      waddr   <= '0;
      img_col <= '0;
      gly_col <= '0;
      gly_row <= '0;
    end else if (cmd_start) begin
      waddr   <= vaddr_t'(yloc) * vaddr_t'(`FRAME_W) + vaddr_t'(xloc);
      img_col <= '0;
      gly_col <= '0;
      gly_row <= '0;
    end else if (vid_inc) begin
      // skip the rest of the frame row at a block row end
      if (row_wrap) waddr <= waddr + vaddr_t'(`FRAME_W + 1) - vaddr_t'(row_w);
      else waddr <= waddr + 1'b1;
      if (img_mode) img_col <= row_end ? '0 : img_col + 1'b1;
      else begin
        gly_col <= gly_col + 1'b1;  // wraps to zero after the last column
        if (gly_row_end) gly_row <= gly_row + 1'b1;
      end
    end
  end

endmodule

// ==== place_ctrl.sv ====
`include "place_consts.svh"

module place_ctrl import place_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic add_img,      // pulse, place an image
  input  logic rem_img,      // pulse, clear an image
  input  logic add_fnt,      // pulse, place a glyph
  input  pix_t rd_pix,       // rom data, one cycle behind the address
  input  logic img_done,     // image rom address past the last pixel
  input  logic row_end,      // last pixel of an image row
  input  logic gly_row_end,  // last pixel of a glyph row
  input  logic gly_last,     // on the last glyph row
  output logic busy,
  output logic we,
  output logic cmd_start,    // load the address counters
  output logic img_mode,     // 1 image rom, 0 font rom
  output logic img_inc,
  output logic gly_inc,
  output logic vid_inc,
  output logic hdr_xhi,
  output logic hdr_xlo,
  output logic hdr_yhi,
  output logic hdr_ylo,
  output pix_t wdata
);

  place_state_t state, nxt_state;
  logic rem_q;   // command is a remove
  logic img_q;   // command works on an image slot
  logic opaque;  // current source pixel gets written

  ////////////////////
  // command capture
  ////////////////////
  assign busy      = (state != IDLE);
  assign cmd_start = ~busy & (add_img | rem_img | add_fnt);  // pulses ignored while busy
  assign img_mode  = img_q;
  assign opaque    = (rd_pix != `TRANSP);
  assign wdata     = rem_q ? '0 : rd_pix;  // remove paints zero through the image mask

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      rem_q <= 1'b0;
      img_q <= 1'b0;
    end else begin
      state <= nxt_state;
      if (cmd_start) begin
        rem_q <= rem_img;            // rem_img wins over add_img
        img_q <= rem_img | add_img;  // add_fnt only when neither
      end
    end
  end

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    nxt_state = state;
    img_inc   = 1'b0;
    gly_inc   = 1'b0;
    vid_inc   = 1'b0;
    we        = 1'b0;
    hdr_xhi   = 1'b0;
    hdr_xlo   = 1'b0;
    hdr_yhi   = 1'b0;
    hdr_ylo   = 1'b0;
    case (state)
      IDLE: begin
        if (rem_img | add_img) nxt_state = HDR_ADV;
        else if (add_fnt) nxt_state = GLY_ADV;
      end
      HDR_ADV: begin  // slot base on the rom, no data yet
        img_inc   = 1'b1;
        nxt_state = HDR_XHI;
      end
      HDR_XHI: begin
        img_inc   = 1'b1;
        hdr_xhi   = 1'b1;
        nxt_state = HDR_XLO;
      end
      HDR_XLO: begin
        img_inc   = 1'b1;
        hdr_xlo   = 1'b1;
        nxt_state = HDR_YHI;
      end
      HDR_YHI: begin
        img_inc   = 1'b1;
        hdr_yhi   = 1'b1;
        nxt_state = HDR_YLO;
      end
      HDR_YLO: begin  // first pixel already addressed
        img_inc   = 1'b1;
        hdr_ylo   = 1'b1;
        nxt_state = IMG_WR;
      end
      IMG_WR: begin
        img_inc = 1'b1;
        vid_inc = 1'b1;
        we      = opaque;
        if (row_end && img_done) nxt_state = IDLE;  // last pixel ends the bottom row
      end
      GLY_ADV: begin  // new strip row on the rom
        gly_inc   = 1'b1;
        nxt_state = GLY_WR;
      end
      GLY_WR: begin
        gly_inc = 1'b1;
        vid_inc = 1'b1;
        we      = opaque;
        if (gly_row_end) nxt_state = gly_last ? IDLE : GLY_ADV;
      end
      default: nxt_state = IDLE;
    endcase
  end

endmodule

// ==== place_pkg.sv ====
package place_pkg;

  // widths that mean something
  typedef logic [5:0]  pix_t;        // 6-bit colour code
  typedef logic [10:0] vaddr_t;      // linear frame address
  typedef logic [5:0]  xcoord_t;     // frame column
  typedef logic [4:0]  ycoord_t;     // frame row
  typedef logic [5:0]  rom_addr_t;   // image rom word address
  typedef logic [4:0]  font_addr_t;  // font strip word address
  typedef logic [11:0] dim_t;        // image width or height, two 6-bit digits
  typedef logic [1:0]  img_idx_t;    // image slot select
  typedef logic        glyph_idx_t;  // glyph select

  // controller states
  typedef enum logic [3:0] {
    IDLE,      // waiting for a command pulse
    HDR_ADV,   // first rom address out, nothing back yet
    HDR_XHI,   // width high digit on rd_pix
    HDR_XLO,   // width low digit
    HDR_YHI,   // height high digit
    HDR_YLO,   // height low digit
    IMG_WR,    // one image pixel per cycle
    GLY_ADV,   // glyph row start, rom catching up
    GLY_WR     // one glyph pixel per cycle
  } place_state_t;

endpackage

// ==== place_consts.svh ====
`ifndef PLACE_CONSTS_SVH
`define PLACE_CONSTS_SVH

////////////////////
// frame geometry
////////////////////
`define FRAME_W      64                       // pixels per frame row
`define FRAME_H      32                       // frame rows
`define FRAME_WORDS  (`FRAME_W * `FRAME_H)    // frame buffer depth

////////////////////
// font strip
////////////////////
`define GLYPH_W      4                        // glyph columns
`define GLYPH_H      4                        // glyph rows
`define GLYPH_CNT    2                        // glyphs side by side in the strip
`define FONT_STRIDE  (`GLYPH_W * `GLYPH_CNT)  // strip row length

////////////////////
// image slots
////////////////////
`define SLOT_WORDS   16                       // words per image slot
`define IMG_CNT      3                        // slots in the image rom
`define HDR_WORDS    4                        // w hi, w lo, h hi, h lo

`define TRANSP       6'h24                    // pixel code never written

`endif
